//--- Makefile
TOP = uart_controller_tb

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | \
		grep "Simulation PASSED" > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- hdl/axil_pkg.sv
package axil_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Master-driven channel signals.
    typedef struct packed {
        logic        aw_valid;
        logic [3:0]  aw_addr;
        logic        w_valid;
        logic [31:0] w_data;
        logic        b_ready;
        logic        ar_valid;
        logic [3:0]  ar_addr;
        logic        r_ready;
    } axil_req_t;

    // Slave-driven channel signals.
    typedef struct packed {
        logic        aw_ready;
        logic        w_ready;
        logic        b_valid;
        axil_resp_e  b_resp;
        logic        ar_ready;
        logic        r_valid;
        logic [31:0] r_data;
        axil_resp_e  r_resp;
    } axil_rsp_t;

endpackage

//--- hdl/axil_uart_regs.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module axil_uart_regs (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t req,
    output axil_pkg::axil_rsp_t rsp,
    output logic                tx_wr,
    output logic [7:0]          tx_data,
    input  logic                tx_full,
    output logic                rx_rd,
    input  logic [7:0]          rx_data,
    input  logic                rx_empty,
    input  logic                rx_push,
    input  logic                rx_full,
    output logic                irq
);

    logic                   b_valid;
    logic                   r_valid;
    axil_pkg::axil_resp_e   b_resp;
    axil_pkg::axil_resp_e   r_resp;
    logic [31:0]            r_data;
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_data_hit;
    logic                   rx_overrun;
    uart_pkg::uart_status_t status;

    // Address and data are taken together, only with no response pending.
    assign wr_fire     = req.aw_valid && req.w_valid && !b_valid;
    assign rd_fire     = req.ar_valid && !r_valid;
    assign wr_data_hit = (req.aw_addr == `UART_REG_DATA);

    assign status.tx_not_full  = !tx_full;
    assign status.rx_not_empty = !rx_empty;
    assign status.rx_overrun   = rx_overrun;

    assign irq = !rx_empty;

    always_comb begin
        rsp.aw_ready = wr_fire;
        rsp.w_ready  = wr_fire;
        rsp.b_valid  = b_valid;
        rsp.b_resp   = b_resp;
        rsp.ar_ready = rd_fire;
        rsp.r_valid  = r_valid;
        rsp.r_data   = r_data;
        rsp.r_resp   = r_resp;
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            tx_data <= req.w_data[7:0];
            b_resp  <= wr_data_hit ? axil_pkg::OKAY : axil_pkg::SLVERR;
        end
        if (rd_fire) begin
            case (req.ar_addr)
                `UART_REG_DATA: begin
                    r_data <= rx_empty ? 32'd0 : {24'd0, rx_data};
                    r_resp <= axil_pkg::OKAY;
                end
                `UART_REG_STATUS: begin
                    r_data <= {29'd0, status};
                    r_resp <= axil_pkg::OKAY;
                end
                default: begin
                    r_data <= 32'd0;
                    r_resp <= axil_pkg::SLVERR;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            b_valid    <= 1'b0;
            r_valid    <= 1'b0;
            tx_wr      <= 1'b0;
            rx_rd      <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            // Byte is dropped when the transmit FIFO is full.
            tx_wr <= wr_fire && wr_data_hit && !tx_full;
            rx_rd <= rd_fire && (req.ar_addr == `UART_REG_DATA) && !rx_empty;
            if (b_valid && req.b_ready) begin
                b_valid <= 1'b0;
            end else if (wr_fire) begin
                b_valid <= 1'b1;
            end
            if (r_valid && req.r_ready) begin
                r_valid <= 1'b0;
            end else if (rd_fire) begin
                r_valid <= 1'b1;
            end
            // A new overrun in the same cycle survives the clear.
            if (rd_fire && req.ar_addr == `UART_REG_STATUS) begin
                rx_overrun <= 1'b0;
            end
            if (rx_push && rx_full) begin
                rx_overrun <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
    parameter int DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [7:0] din,
    input  logic       rd_en,
    output logic [7:0] dout,
    output logic       full,
    output logic       empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head of queue is always presented.
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/uart_controller.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_controller (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp,
    input  logic                rxd,
    output logic                txd,
    output logic                irq
);

    logic       tx_wr;
    logic [7:0] tx_wdata;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_rd;
    logic [7:0] tx_dout;
    logic       rx_push;
    logic [7:0] rx_byte;
    logic       rx_rd;
    logic [7:0] rx_dout;
    logic       rx_full;
    logic       rx_empty;

    axil_uart_regs u_regs (
        .clk,
        .rst,
        .req      (axil_req),
        .rsp      (axil_rsp),
        .tx_wr    (tx_wr),
        .tx_data  (tx_wdata),
        .tx_full  (tx_full),
        .rx_rd    (rx_rd),
        .rx_data  (rx_dout),
        .rx_empty (rx_empty),
        .rx_push  (rx_push),
        .rx_full  (rx_full),
        .irq      (irq)
    );

    byte_fifo #(.DEPTH(`UART_FIFO_DEPTH)) tx_fifo (
        .clk,
        .rst,
        .wr_en (tx_wr),
        .din   (tx_wdata),
        .rd_en (tx_rd),
        .dout  (tx_dout),
        .full  (tx_full),
        .empty (tx_empty)
    );

    byte_fifo #(.DEPTH(`UART_FIFO_DEPTH)) rx_fifo (
        .clk,
        .rst,
        .wr_en (rx_push),
        .din   (rx_byte),
        .rd_en (rx_rd),
        .dout  (rx_dout),
        .full  (rx_full),
        .empty (rx_empty)
    );

    uart_tx u_tx (
        .clk,
        .rst,
        .fifo_empty (tx_empty),
        .fifo_data  (tx_dout),
        .fifo_rd    (tx_rd),
        .txd        (txd),
        .busy       ()
    );

    uart_rx u_rx (
        .clk,
        .rst,
        .rxd      (rxd),
        .rx_valid (rx_push),
        .rx_data  (rx_byte)
    );

endmodule

//--- hdl/uart_pkg.sv
package uart_pkg;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    // STATUS register image, tx_not_full in bit 0.
    typedef struct packed {
        logic rx_overrun;
        logic rx_not_empty;
        logic tx_not_full;
    } uart_status_t;

endpackage

//--- hdl/uart_rx.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic       rx_valid,
    output logic [7:0] rx_data
);

    localparam int CPB  = `UART_CLKS_PER_BIT;
    localparam int HALF = CPB / 2;
    localparam int CW   = $clog2(CPB);

    uart_pkg::rx_state_e state;
    logic [CW-1:0]       baud_cnt;
    logic [2:0]          bit_idx;
    logic                rxd_meta;
    logic                rxd_sync;
    logic                rxd_prev;
    logic                fall;
    logic                half_end;
    logic                bit_end;

    assign fall     = rxd_prev && !rxd_sync;
    assign half_end = (baud_cnt == CW'(HALF - 1));
    assign bit_end  = (baud_cnt == CW'(CPB - 1));

    // Two-flop synchronizer plus one for edge detect.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && bit_end) begin
            rx_data <= {rxd_sync, rx_data[7:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_pkg::RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                uart_pkg::RX_IDLE: begin
                    baud_cnt <= '0;
                    if (fall) begin
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    // Mid start bit. A high line here was only a glitch.
                    if (half_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::RX_STOP;
                        end
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (bit_end) begin
                        state    <= uart_pkg::RX_IDLE;
                        rx_valid <= rxd_sync;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       fifo_empty,
    input  logic [7:0] fifo_data,
    output logic       fifo_rd,
    output logic       txd,
    output logic       busy
);

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);

    uart_pkg::tx_state_e state;
    logic [CW-1:0]       baud_cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift_reg;
    logic                bit_end;

    assign bit_end = (baud_cnt == CW'(CPB - 1));

    // Take a byte as soon as the serializer is free.
    assign fifo_rd = (state == uart_pkg::TX_IDLE) && !fifo_empty;
    assign busy    = (state != uart_pkg::TX_IDLE) || fifo_rd;

    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            shift_reg <= fifo_data;
        end else if (state == uart_pkg::TX_DATA && bit_end) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_pkg::TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            txd      <= 1'b1;
        end else begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                uart_pkg::TX_IDLE: begin
                    baud_cnt <= '0;
                    if (fifo_rd) begin
                        state <= uart_pkg::TX_START;
                        txd   <= 1'b0;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                        txd     <= shift_reg[0];
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            // Next bit, LSB first.
                            txd <= shift_reg[1];
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

//--- include/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Serial bit time in clk cycles.
`define UART_CLKS_PER_BIT 8

// Entries in each byte FIFO.
`define UART_FIFO_DEPTH 4

// Register byte offsets on the AXI4-Lite port.
`define UART_REG_DATA   4'h0
`define UART_REG_STATUS 4'h4

`endif

//--- list.f
+incdir+include
hdl/axil_pkg.sv
hdl/uart_pkg.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/axil_uart_regs.sv
hdl/uart_controller.sv
verification/uart_controller_asserts.sv
verification/uart_controller_tb.sv

//--- verification/uart_controller_asserts.sv
`timescale 1ns/1ps

module uart_controller_asserts (
    input logic                clk,
    input logic                rst,
    input axil_pkg::axil_req_t axil_req,
    input axil_pkg::axil_rsp_t axil_rsp,
    input logic                irq,
    input logic                txd,
    input logic                rx_push,
    input logic                rx_rd,
    input logic                tx_busy
);

    int failures = 0;

    // Responses stay up until the master takes them.
    b_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
        else begin
            $error("b_valid dropped before b_ready was seen");
            failures++;
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid)
        else begin
            $error("r_valid dropped before r_ready was seen");
            failures++;
        end

    // irq rises only on a received byte and falls only on a pop.
    irq_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(irq) |-> $past(rx_push))
        else begin
            $error("irq rose without a byte pushed into the receive FIFO");
            failures++;
        end

    irq_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(irq) |-> $past(rx_rd))
        else begin
            $error("irq fell without a pop of the receive FIFO");
            failures++;
        end

    // Line idles high.
    txd_idle: assert property (@(posedge clk) disable iff (rst)
        !tx_busy |-> txd)
        else begin
            $error("txd is low while the transmitter is idle");
            failures++;
        end

endmodule

bind uart_controller uart_controller_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .irq      (irq),
    .txd      (txd),
    .rx_push  (rx_push),
    .rx_rd    (rx_rd),
    .tx_busy  (u_tx.busy)
);

//--- verification/uart_controller_tb.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_controller_tb;

    localparam int CPB       = `UART_CLKS_PER_BIT;
    localparam int DEPTH     = `UART_FIFO_DEPTH;
    localparam int FRAME     = 10 * CPB;
    localparam int NUM_TESTS = 6;

    logic                clk;
    logic                rst;
    axil_pkg::axil_req_t axil_req;
    axil_pkg::axil_rsp_t axil_rsp;
    logic                rxd;
    logic                txd;
    logic                irq;
    logic                loop_en;
    logic                rxd_drv;
    logic [31:0]         rng_state;
    logic [7:0]          sent [$];
    int                  errors;
    int                  test_errors;
    int                  tests_done;
    int                  tests_failed;
    int                  rx_frames;

    // Loopback, or a directly driven line.
    assign rxd = loop_en ? txd : rxd_drv;

    uart_controller uut (.clk, .rst, .axil_req, .axil_rsp, .rxd, .txd, .irq);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_frames <= 0;
        end else if (uut.rx_push) begin
            rx_frames <= rx_frames + 1;
        end
    end

    function automatic logic [7:0] random_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_done++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_done, name);
        end else begin
            $display("Test %0d %s: ok", tests_done, name);
        end
        test_errors = errors;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             output axil_pkg::axil_resp_e resp);
        @(posedge clk);
        axil_req.aw_valid <= 1'b1;
        axil_req.aw_addr  <= addr;
        axil_req.w_valid  <= 1'b1;
        axil_req.w_data   <= data;
        @(negedge clk);
        while (!axil_rsp.aw_ready) @(negedge clk);
        check_value("w_ready", 32'd1, 32'(axil_rsp.w_ready));
        @(posedge clk);
        axil_req.aw_valid <= 1'b0;
        axil_req.w_valid  <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.b_valid) @(negedge clk);
        resp = axil_rsp.b_resp;
        // Response waits one cycle before it is taken.
        @(posedge clk);
        axil_req.b_ready <= 1'b1;
        @(posedge clk);
        axil_req.b_ready <= 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                            output axil_pkg::axil_resp_e resp);
        @(posedge clk);
        axil_req.ar_valid <= 1'b1;
        axil_req.ar_addr  <= addr;
        @(negedge clk);
        while (!axil_rsp.ar_ready) @(negedge clk);
        @(posedge clk);
        axil_req.ar_valid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.r_valid) @(negedge clk);
        data = axil_rsp.r_data;
        resp = axil_rsp.r_resp;
        @(posedge clk);
        axil_req.r_ready <= 1'b1;
        @(posedge clk);
        axil_req.r_ready <= 1'b0;
    endtask

    initial begin
        repeat (NUM_TESTS * 6 * FRAME + 1000) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        axil_pkg::axil_resp_e resp;
        logic [31:0]          data;
        int                   base;
        int                   total;
        rst          = 1'b1;
        axil_req     = '0;
        loop_en      = 1'b1;
        rxd_drv      = 1'b1;
        rng_state    = 32'h2aeb_ff0e;
        errors       = 0;
        test_errors  = 0;
        tests_done   = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        read_reg(`UART_REG_STATUS, data, resp);
        check_value("r_resp", 32'(axil_pkg::OKAY), 32'(resp));
        check_value("status", 32'd1, data);
        @(negedge clk);
        check_value("irq", 32'd0, 32'(irq));
        check_value("txd", 32'd1, 32'(txd));
        end_test("reset state");

        for (int i = 0; i < 3; i++) begin
            sent.push_back(random_byte());
            write_reg(`UART_REG_DATA, 32'(sent[i]), resp);
            check_value("b_resp", 32'(axil_pkg::OKAY), 32'(resp));
        end
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            while (!irq) @(negedge clk);
            read_reg(`UART_REG_DATA, data, resp);
            check_value("r_data", 32'(sent[i]), data);
        end
        @(negedge clk);
        check_value("irq", 32'd0, 32'(irq));
        end_test("loopback");

        // One byte goes to the serializer, the rest fill the FIFO.
        sent.delete();
        base = rx_frames;
        for (int i = 0; i < DEPTH + 1; i++) begin
            sent.push_back(random_byte());
            write_reg(`UART_REG_DATA, 32'(sent[i]), resp);
        end
        read_reg(`UART_REG_STATUS, data, resp);
        check_value("status.tx_not_full", 32'd0, 32'(data[0]));
        end_test("transmit FIFO full");

        while (data[0] == 1'b0) begin
            read_reg(`UART_REG_STATUS, data, resp);
        end
        sent.push_back(random_byte());
        write_reg(`UART_REG_DATA, 32'(sent[DEPTH + 1]), resp);
        while (rx_frames != base + DEPTH + 2) @(negedge clk);
        read_reg(`UART_REG_STATUS, data, resp);
        check_value("status[2:1]", 32'd3, 32'(data[2:1]));
        read_reg(`UART_REG_STATUS, data, resp);
        check_value("status.rx_overrun", 32'd0, 32'(data[2]));
        end_test("receive overrun");

        write_reg(`UART_REG_STATUS, 32'h5a, resp);
        check_value("b_resp", 32'(axil_pkg::SLVERR), 32'(resp));
        read_reg(4'h8, data, resp);
        check_value("r_resp", 32'(axil_pkg::SLVERR), 32'(resp));
        for (int i = 0; i < DEPTH; i++) begin
            read_reg(`UART_REG_DATA, data, resp);
            check_value("r_data", 32'(sent[i]), data);
        end
        read_reg(`UART_REG_DATA, data, resp);
        check_value("r_data", 32'd0, data);
        check_value("r_resp", 32'(axil_pkg::OKAY), 32'(resp));
        end_test("error responses");

        // Half a bit low, then a full frame of idle line.
        @(posedge clk);
        loop_en <= 1'b0;
        rxd_drv <= 1'b0;
        repeat (CPB / 2) @(posedge clk);
        rxd_drv <= 1'b1;
        repeat (FRAME) @(posedge clk);
        read_reg(`UART_REG_STATUS, data, resp);
        check_value("status.rx_not_empty", 32'd0, 32'(data[1]));
        end_test("start bit glitch");

        total = errors + uut.u_asserts.failures;
        $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_done, tests_failed, errors, uut.u_asserts.failures);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
